//--- hw/normCorrPkg.sv
package normCorrPkg;

	////////////////////////////////////////////////////////////
	// Lengths
	localparam int subframeLength = 40;   // Samples per window
	localparam int yDepth         = 64;
	localparam int maxLagSpan     = 23;   // Last window still ends inside y

	typedef logic signed [15:0] sample_t;    // Q15
	typedef logic signed [31:0] acc_t;
	typedef logic        [7:0]  lag_t;
	typedef logic        [5:0]  sampleIndex_t;
	typedef logic        [7:0]  busAddr_t;   // Word address
	typedef logic        [31:0] busData_t;

	////////////////////////////////////////////////////////////
	// Register map
	localparam busAddr_t xnBase         = 8'h00;
	localparam busAddr_t yBase          = 8'h40;
	localparam busAddr_t controlAddr    = 8'h80;
	localparam busAddr_t statusAddr     = 8'h81;
	localparam busAddr_t bestLagAddr    = 8'h82;
	localparam busAddr_t bestValuesAddr = 8'h83;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		busAddr_t adr;
		busData_t dat;
	} wbRequest_t;

	typedef struct packed {
		logic     ack;
		busData_t dat;
	} wbResponse_t;

	typedef struct packed {
		logic         en;
		logic         selY;   // 0 writes xn
		sampleIndex_t index;
		sample_t      sample;
	} sampleWrite_t;

	typedef struct packed {
		logic valid;
		logic first;
		logic last;
	} macControl_t;

	typedef struct packed {
		logic valid;
		lag_t lag;
		logic finalLag;
	} lagTag_t;

	typedef struct packed {
		logic    valid;
		sample_t high;
	} macResult_t;

	typedef struct packed {
		lag_t    lag;
		sample_t correlation;
		sample_t energy;
	} bestResult_t;

	typedef enum logic [1:0] {
		idle,
		issue,
		drain
	} sequencerState_t;

endpackage

//--- hw/wishboneRegs.sv
`timescale 1ns/1ps

module wishboneRegs
(
	input  logic                      clk,
	input  logic                      reset,
	input  normCorrPkg::wbRequest_t   wbIn,
	output normCorrPkg::wbResponse_t  wbOut,
	output normCorrPkg::sampleWrite_t sampleWrite,
	output logic                      start,
	output normCorrPkg::lag_t         tMin,
	output normCorrPkg::lag_t         tMax,
	input  logic                      runDone,
	input  normCorrPkg::bestResult_t  best
);
	import normCorrPkg::*;

	logic     ack;
	logic     busy;
	logic     done;
	logic     rangeError;
	logic     cycleActive;
	logic     writeAck;
	logic     controlWrite;
	logic     rangeBad;
	logic     inXn;
	logic     inY;
	lag_t     reqMin;
	lag_t     reqMax;
	lag_t     reqSpan;
	busData_t readData;
	busData_t readReg;

	assign cycleActive  = wbIn.cyc && wbIn.stb;
	assign writeAck     = ack && cycleActive && wbIn.we;   // Master still holds the request
	assign inXn         = (wbIn.adr - xnBase) < subframeLength;
	assign inY          = (wbIn.adr - yBase) < yDepth;

	// Start request fields
	assign reqMin       = wbIn.dat[7:0];
	assign reqMax       = wbIn.dat[15:8];
	assign reqSpan      = reqMax - reqMin;
	assign rangeBad     = (reqMax < reqMin) || (reqSpan > maxLagSpan);
	assign controlWrite = writeAck && (wbIn.adr == controlAddr) && wbIn.dat[16] && !busy;

	// Sample loads are dropped during a run
	always_comb
	begin
		sampleWrite.en     = writeAck && !busy && (inXn || inY);
		sampleWrite.selY   = inY;
		sampleWrite.index  = sampleIndex_t'(wbIn.adr);   // Both bases are 64-word aligned
		sampleWrite.sample = wbIn.dat[15:0];
	end

	always_comb
	begin
		case (wbIn.adr)
			statusAddr:     readData = {29'd0, rangeError, done, busy};
			bestLagAddr:    readData = {24'd0, best.lag};
			bestValuesAddr: readData = {best.correlation, best.energy};
			default:        readData = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack        <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			rangeError <= 1'b0;
			start      <= 1'b0;
		end
		else
		begin
			ack   <= cycleActive && !ack;   // Single-cycle ack with no wait states
			start <= 1'b0;
			if (runDone)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (controlWrite)
			begin
				if (rangeBad)
					rangeError <= 1'b1;
				else
				begin
					rangeError <= 1'b0;
					done       <= 1'b0;
					busy       <= 1'b1;
					start      <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (cycleActive && !ack)
			readReg <= readData;
		if (controlWrite && !rangeBad)
		begin
			tMin <= reqMin;
			tMax <= reqMax;
		end
	end

	assign wbOut.ack = ack;
	assign wbOut.dat = readReg;

endmodule

//--- hw/sampleStore.sv
`timescale 1ns/1ps

module sampleStore
(
	input  logic                      clk,
	input  normCorrPkg::sampleWrite_t sampleWrite,
	input  normCorrPkg::sampleIndex_t xnIndex,
	input  normCorrPkg::sampleIndex_t yIndex,
	output normCorrPkg::sample_t      xnSample,
	output normCorrPkg::sample_t      ySample
);
	import normCorrPkg::*;

	sample_t xnMem [subframeLength];
	sample_t yMem  [yDepth];

	logic xnWrite;
	logic yWrite;

	// One bus port shared by both arrays
	assign xnWrite = sampleWrite.en && !sampleWrite.selY;
	assign yWrite  = sampleWrite.en && sampleWrite.selY;

	////////////////////////////////////////////////////////////
	// Target vector
	always_ff @(posedge clk)
	begin
		if (xnWrite)
			xnMem[sampleWrite.index] <= sampleWrite.sample;
		xnSample <= xnMem[xnIndex];   // Registered read
	end

	////////////////////////////////////////////////////////////
	// Filtered excitation
	always_ff @(posedge clk)
	begin
		if (yWrite)
			yMem[sampleWrite.index] <= sampleWrite.sample;
		ySample <= yMem[yIndex];
	end

endmodule

//--- hw/lagSequencer.sv
`timescale 1ns/1ps

module lagSequencer
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  normCorrPkg::lag_t         tMin,
	input  normCorrPkg::lag_t         tMax,
	output normCorrPkg::sampleIndex_t xnIndex,
	output normCorrPkg::sampleIndex_t yIndex,
	output normCorrPkg::macControl_t  macControl,
	output normCorrPkg::lagTag_t      lagTag
);
	import normCorrPkg::*;

	sequencerState_t state;
	lag_t            lagCount;
	lag_t            lagOffset;
	sampleIndex_t    jCount;
	logic            lastPair;
	logic            finalLag;
	macControl_t     issueControl;
	lagTag_t         issueTag;
	lagTag_t         tagStage;

	assign lastPair  = jCount == sampleIndex_t'(subframeLength - 1);
	assign finalLag  = lagCount == tMax;
	assign lagOffset = tMax - lagCount;   // Window start for this lag

	assign xnIndex = jCount;
	assign yIndex  = lagOffset[5:0] + jCount;

	always_comb
	begin
		issueControl.valid = state == issue;
		issueControl.first = (state == issue) && (jCount == '0);
		issueControl.last  = (state == issue) && lastPair;
		issueTag.valid     = (state == issue) && lastPair;
		issueTag.lag       = lagCount;
		issueTag.finalLag  = finalLag;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= idle;
			lagCount   <= '0;
			jCount     <= '0;
			macControl <= '0;
			tagStage   <= '0;
			lagTag     <= '0;
		end
		else
		begin
			macControl <= issueControl;   // Lines up with the sample read
			tagStage   <= issueTag;
			lagTag     <= tagStage;       // Meets the MAC results
			case (state)
				idle:
					if (start)
					begin
						lagCount <= tMin;
						jCount   <= '0;
						state    <= issue;
					end
				issue:
					if (lastPair)
					begin
						jCount   <= '0;
						lagCount <= lagCount + 8'd1;
						if (finalLag)
							state <= drain;
					end
					else
						jCount <= jCount + 6'd1;
				drain:
					if (lagTag.valid && lagTag.finalLag)   // Last tag has left
						state <= idle;
				default:
					state <= idle;
			endcase
		end
	end

endmodule

//--- hw/lagMac.sv
`timescale 1ns/1ps

module lagMac
(
	input  logic                     clk,
	input  logic                     reset,
	input  normCorrPkg::macControl_t control,
	input  normCorrPkg::sample_t     a,
	input  normCorrPkg::sample_t     b,
	output normCorrPkg::macResult_t  result
);
	import normCorrPkg::*;

	acc_t               sum;
	acc_t               base;
	acc_t               product;
	acc_t               doubled;
	acc_t               nextSum;
	logic signed [32:0] wideSum;
	logic               resultValid;
	sample_t            resultHigh;

	always_comb
	begin
		product = a * b;
		// L_mult, only -1 * -1 overflows
		if (product == 32'sh4000_0000)
			doubled = 32'sh7FFF_FFFF;
		else
			doubled = product <<< 1;
		base    = control.first ? '0 : sum;
		wideSum = {base[31], base} + {doubled[31], doubled};
		if (wideSum[32] != wideSum[31])
			nextSum = wideSum[32] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;   // Saturate
		else
			nextSum = wideSum[31:0];
	end

	always_ff @(posedge clk)
	begin
		if (control.valid)
			sum <= nextSum;
		if (control.valid && control.last)
			resultHigh <= nextSum[31:16];   // High word only
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= control.valid && control.last;
	end

	assign result = '{valid: resultValid, high: resultHigh};

endmodule

//--- hw/bestLagSelector.sv
`timescale 1ns/1ps

module bestLagSelector
(
	input  logic                     clk,
	input  logic                     reset,
	input  normCorrPkg::macResult_t  energy,
	input  normCorrPkg::macResult_t  correlation,
	input  normCorrPkg::lagTag_t     lagTag,
	output normCorrPkg::bestResult_t best,
	output logic                     runDone
);
	import normCorrPkg::*;

	sample_t            corrIn;
	sample_t            energyIn;
	sample_t            corrBest;
	sample_t            energyBest;
	logic signed [31:0] corrSq;
	logic signed [31:0] corrBestSq;
	logic signed [47:0] candidateScore;
	logic signed [47:0] bestScore;
	logic               firstOfRun;
	logic               resultsReady;
	logic               better;
	logic               take;

	assign corrIn     = correlation.high;
	assign energyIn   = energy.high;
	assign corrBest   = best.correlation;
	assign energyBest = best.energy;

	////////////////////////////////////////////////////////////
	// Cross-multiplied squares stand in for c / sqrt(E)
	assign corrSq         = corrIn * corrIn;
	assign corrBestSq     = corrBest * corrBest;
	assign candidateScore = corrSq * energyBest;   // Full width, no rounding
	assign bestScore      = corrBestSq * energyIn;

	assign resultsReady = lagTag.valid && energy.valid && correlation.valid;
	assign better       = (corrIn > 0) && (candidateScore > bestScore);   // Ties keep earlier lag
	assign take         = firstOfRun || better;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			best       <= '0;
			runDone    <= 1'b0;
			firstOfRun <= 1'b1;
		end
		else
		begin
			runDone <= resultsReady && lagTag.finalLag;
			if (resultsReady)
			begin
				firstOfRun <= lagTag.finalLag;   // Next tag opens a new run
				if (take)
					best <= '{lag: lagTag.lag, correlation: corrIn, energy: energyIn};
			end
		end
	end

endmodule

//--- hw/normCorrTop.sv
`timescale 1ns/1ps

module normCorrTop
(
	input  logic                     clk,
	input  logic                     reset,
	input  normCorrPkg::wbRequest_t  wbIn,
	output normCorrPkg::wbResponse_t wbOut
);
	import normCorrPkg::*;

	sampleWrite_t sampleWrite;
	logic         start;
	logic         runDone;
	lag_t         tMin;
	lag_t         tMax;
	sampleIndex_t xnIndex;
	sampleIndex_t yIndex;
	sample_t      xnSample;
	sample_t      ySample;
	macControl_t  macControl;
	lagTag_t      lagTag;
	macResult_t   energyResult;
	macResult_t   correlationResult;
	bestResult_t  best;

	wishboneRegs regs (.clk, .reset, .wbIn, .wbOut, .sampleWrite, .start, .tMin, .tMax,
		.runDone, .best);

	sampleStore store (.clk, .sampleWrite, .xnIndex, .yIndex, .xnSample, .ySample);

	lagSequencer sequencer (.clk, .reset, .start, .tMin, .tMax, .xnIndex, .yIndex,
		.macControl, .lagTag);

	// Window energy y.y
	lagMac energyMac (.clk, .reset, .control(macControl), .a(ySample), .b(ySample),
		.result(energyResult));

	// Cross-correlation xn.y
	lagMac correlationMac (.clk, .reset, .control(macControl), .a(xnSample), .b(ySample),
		.result(correlationResult));

	bestLagSelector selector (.clk, .reset, .energy(energyResult),
		.correlation(correlationResult), .lagTag, .best, .runDone);

endmodule

//--- testbench/normCorrTb.sv
`timescale 1ns/1ps

module normCorrTb;
	import normCorrPkg::*;

	localparam int timeoutCycles = 20 * 24 * 40 * 2;   // Twice 20 runs of 24 lags

	logic        clk;
	logic        reset;
	wbRequest_t  wbIn;
	wbResponse_t wbOut;
	int          cycleCount;
	sample_t     xnModel [subframeLength];
	sample_t     yModel  [yDepth];
	lag_t        lastLag;      // Results last read back from the DUT
	sample_t     lastCorr;
	sample_t     lastEnergy;

	normCorrTop DUT (.clk, .reset, .wbIn, .wbOut);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout: the test did not finish within %0d cycles", timeoutCycles);
			stopWithFailure();
		end
	end

	task automatic stopWithFailure();
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic lagMatches(input string name, input lag_t got, input lag_t expected);
		if (got !== expected)
		begin
			$display("[FAIL] %s: got %h, expected %h", name, got, expected);
			stopWithFailure();
		end
	endtask

	task automatic sampleMatches(input string name, input sample_t got, input sample_t expected);
		if (got !== expected)
		begin
			$display("[FAIL] %s: got %h, expected %h", name, got, expected);
			stopWithFailure();
		end
	endtask

	task automatic statusMatches(input logic [2:0] got, input logic [2:0] expected);
		if (got !== expected)
		begin
			$display("[FAIL] status: got %h, expected %h", got, expected);
			stopWithFailure();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Wishbone classic master driven 1 ns after a rising edge
	task automatic writeWord(input busAddr_t addr, input busData_t data);
		wbIn = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
		do
		begin
			@(posedge clk);
			#1;
		end while (!wbOut.ack);
		@(posedge clk);   // Write lands on this edge
		#1;
		wbIn.cyc = 1'b0;
		wbIn.stb = 1'b0;
		wbIn.we  = 1'b0;
	endtask

	task automatic readWord(input busAddr_t addr, output busData_t data);
		wbIn = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: '0};
		do
		begin
			@(posedge clk);
			#1;
		end while (!wbOut.ack);
		data = wbOut.dat;
		@(posedge clk);
		#1;
		wbIn.cyc = 1'b0;
		wbIn.stb = 1'b0;
	endtask

	task automatic randomizeSamples(input int shift);
		busData_t raw;
		for (int k = 0; k < yDepth; k++)
		begin
			raw = $urandom;
			yModel[k] = $signed(raw[15:0]) >>> shift;
			if (k < subframeLength)
				xnModel[k] = $signed(raw[31:16]) >>> shift;
		end
	endtask

	task automatic loadSamples();
		for (int k = 0; k < subframeLength; k++)
			writeWord(busAddr_t'(xnBase + k), {16'd0, xnModel[k]});
		for (int k = 0; k < yDepth; k++)
			writeWord(busAddr_t'(yBase + k), {16'd0, yModel[k]});
	endtask

	task automatic pickRange(output lag_t lo, output lag_t hi);
		int span;
		span = $urandom % 24;
		lo   = lag_t'(20 + $urandom % (124 - span));   // Keeps tMax within 143
		hi   = lo + lag_t'(span);
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	function automatic sample_t windowHigh(input int offset, input bit useXn);
		longint  sum;
		longint  term;
		sample_t a;
		sum = 0;
		for (int j = 0; j < subframeLength; j++)
		begin
			a    = useXn ? xnModel[j] : yModel[offset + j];
			term = 2 * longint'(a) * longint'(yModel[offset + j]);
			if (term > 64'sd2147483647)
				term = 64'sd2147483647;   // -1 times -1
			sum = sum + term;
			if (sum > 64'sd2147483647)
				sum = 64'sd2147483647;
			else if (sum < -64'sd2147483648)
				sum = -64'sd2147483648;
		end
		return sample_t'(sum >>> 16);
	endfunction

	task automatic predictBest(input lag_t lo, input lag_t hi, output lag_t lag,
		output sample_t corr, output sample_t energy);
		sample_t c;
		sample_t e;
		longint  candidate;
		longint  incumbent;
		for (int i = lo; i <= hi; i++)
		begin
			c         = windowHigh(hi - i, 1'b1);
			e         = windowHigh(hi - i, 1'b0);
			candidate = longint'(c) * longint'(c) * longint'(energy);
			incumbent = longint'(corr) * longint'(corr) * longint'(e);
			if (i == lo || (c > 0 && candidate > incumbent))
			begin
				lag    = lag_t'(i);
				corr   = c;
				energy = e;
			end
		end
	endtask

	task automatic resultsMatch(input lag_t lag, input sample_t corr, input sample_t energy);
		busData_t data;
		readWord(bestLagAddr, data);
		lagMatches("bestLag", data[7:0], lag);
		readWord(bestValuesAddr, data);
		sampleMatches("bestCorrelation", data[31:16], corr);
		sampleMatches("bestEnergy", data[15:0], energy);
		lastLag    = lag;
		lastCorr   = corr;
		lastEnergy = energy;
	endtask

	task automatic startRun(input lag_t lo, input lag_t hi);
		writeWord(controlAddr, {15'd0, 1'b1, hi, lo});
	endtask

	task automatic finishRun(input lag_t lo, input lag_t hi);
		busData_t data;
		lag_t     lag;
		sample_t  corr;
		sample_t  energy;
		do
			readWord(statusAddr, data);
		while (!data[1]);   // Poll for done
		statusMatches(data[2:0], 3'b010);
		predictBest(lo, hi, lag, corr, energy);
		resultsMatch(lag, corr, energy);
	endtask

	task automatic runAndCheck(input lag_t lo, input lag_t hi);
		busData_t data;
		startRun(lo, hi);
		readWord(statusAddr, data);
		statusMatches(data[2:0], 3'b001);   // busy only
		finishRun(lo, hi);
	endtask

	task automatic rejectRange(input lag_t lo, input lag_t hi);
		busData_t data;
		startRun(lo, hi);
		repeat (3)
		begin
			readWord(statusAddr, data);
			statusMatches(data[2:0], 3'b110);   // Done kept and busy low
		end
		resultsMatch(lastLag, lastCorr, lastEnergy);
	endtask

	initial
	begin
		lag_t        lo;
		lag_t        hi;
		busData_t    data;
		clk        = 1'b0;
		reset      = 1'b1;
		wbIn       = '0;
		cycleCount = 0;
		void'($urandom(32'h504f_1aef));
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset values
		readWord(statusAddr, data);
		statusMatches(data[2:0], 3'b000);
		resultsMatch('0, '0, '0);

		// Random runs with mixed amplitudes
		for (int run = 0; run < 15; run++)
		begin
			randomizeSamples($urandom % 8);
			loadSamples();
			pickRange(lo, hi);
			runAndCheck(lo, hi);
		end

		// Full-scale negative samples
		for (int k = 0; k < yDepth; k++)
		begin
			yModel[k] = 16'sh8000;
			if (k < subframeLength)
				xnModel[k] = 16'sh8000;
		end
		loadSamples();
		runAndCheck(8'd40, 8'd55);
		resultsMatch(8'd40, 16'sh7FFF, 16'sh7FFF);

		// Bad ranges
		rejectRange(8'd60, 8'd50);
		rejectRange(8'd30, 8'd54);
		runAndCheck(8'd30, 8'd53);

		// y writes during a run
		randomizeSamples(3);
		loadSamples();
		pickRange(lo, hi);
		startRun(lo, hi);
		for (int k = 0; k < 8; k++)
			writeWord(busAddr_t'(yBase + k), $urandom);
		finishRun(lo, hi);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- verilog.f
hw/normCorrPkg.sv
hw/wishboneRegs.sv
hw/sampleStore.sv
hw/lagSequencer.sv
hw/lagMac.sv
hw/bestLagSelector.sv
hw/normCorrTop.sv
testbench/normCorrTb.sv
